// File: rtl/fxp_div_pkg.sv
package fxp_div_pkg;

	// --------------------------------------------------
	// operand formats
	// --------------------------------------------------

	// dividend Q8.8
	localparam int DVD_INT  = 8;
	localparam int DVD_FRAC = 8;

	// divisor Q4.4
	localparam int DVS_INT  = 4;
	localparam int DVS_FRAC = 4;

	// quotient Q8.8
	localparam int QUO_INT  = 8;
	localparam int QUO_FRAC = 8;

	// common grid, wide enough for divisor shifted over every quotient bit
	localparam int ALN_INT  = (QUO_INT + DVS_INT > DVD_INT) ? QUO_INT + DVS_INT : DVD_INT;
	localparam int ALN_FRAC = (QUO_FRAC + DVS_FRAC > DVD_FRAC) ? QUO_FRAC + DVS_FRAC : DVD_FRAC;

	// --------------------------------------------------
	// derived widths
	// --------------------------------------------------

	localparam int DVD_W = DVD_INT + DVD_FRAC;
	localparam int DVS_W = DVS_INT + DVS_FRAC;
	localparam int QUO_W = QUO_INT + QUO_FRAC;
	localparam int ALN_W = ALN_INT + ALN_FRAC;

	// operand reg + one stage per quotient bit + round + saturate
	localparam int DIV_LATENCY = QUO_W + 3;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------

	typedef logic signed [DVD_W-1:0] dividend_t;
	typedef logic signed [DVS_W-1:0] divisor_t;

	// quotient, also used for the unsigned quotient magnitude
	typedef logic [QUO_W-1:0] quotient_t;

	// magnitudes and partial sums on the Q12.12 grid
	typedef logic [ALN_W-1:0] aligned_t;

endpackage

// File: rtl/div_operand_stage.sv
`timescale 1ns/1ps

module div_operand_stage (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   vld,
	input  fxp_div_pkg::dividend_t dividend,
	input  fxp_div_pkg::divisor_t  divisor,
	output logic                   out_vld,
	output logic                   out_sign,
	output fxp_div_pkg::aligned_t  out_dvd,
	output fxp_div_pkg::aligned_t  out_dvs
);

	import fxp_div_pkg::*;

	// fraction shifts onto the common grid
	localparam int DVD_SHL = ALN_FRAC - DVD_FRAC;
	localparam int DVS_SHL = ALN_FRAC - DVS_FRAC;

	logic [DVD_W-1:0] dvd_mag;
	logic [DVS_W-1:0] dvs_mag;
	aligned_t         dvd_aln;
	aligned_t         dvs_aln;
	logic             res_sign;

	// --------------------------------------------------
	// magnitudes and result sign
	// --------------------------------------------------

	// most negative value maps to 2^(w-1), still fits unsigned
	always_comb begin
		dvd_mag = dividend[DVD_W-1] ? DVD_W'(-dividend) : DVD_W'(dividend);
		dvs_mag = divisor[DVS_W-1] ? DVS_W'(-divisor) : DVS_W'(divisor);
		res_sign = dividend[DVD_W-1] ^ divisor[DVS_W-1];
	end

	// zero extend, then line up the binary points
	always_comb begin
		dvd_aln = aligned_t'(dvd_mag) << DVD_SHL;
		dvs_aln = aligned_t'(dvs_mag) << DVS_SHL;
	end

	// --------------------------------------------------
	// stage register
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			out_vld  <= 1'b0;
			out_sign <= 1'b0;
			out_dvd  <= '0;
			out_dvs  <= '0;
		end else begin
			out_vld  <= vld;
			out_sign <= res_sign;
			out_dvd  <= dvd_aln;
			out_dvs  <= dvs_aln;
		end
	end

endmodule

// File: rtl/div_restoring_stage.sv
`timescale 1ns/1ps

module div_restoring_stage #(
	parameter int STAGE = 0
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   in_vld,
	input  logic                   in_sign,
	input  fxp_div_pkg::aligned_t  in_dvd,
	input  fxp_div_pkg::aligned_t  in_dvs,
	input  fxp_div_pkg::aligned_t  in_acc,
	input  fxp_div_pkg::quotient_t in_quo,
	output logic                   out_vld,
	output logic                   out_sign,
	output fxp_div_pkg::aligned_t  out_dvd,
	output fxp_div_pkg::aligned_t  out_dvs,
	output fxp_div_pkg::aligned_t  out_acc,
	output fxp_div_pkg::quotient_t out_quo
);

	import fxp_div_pkg::*;

	// quotient bit decided here, msb first
	localparam int QBIT = QUO_W - 1 - STAGE;

	// integer bits shift the divisor up, fraction bits shift it down
	localparam int SHL = (STAGE < QUO_INT) ? QUO_INT - 1 - STAGE : 0;
	localparam int SHR = (STAGE < QUO_INT) ? 0 : STAGE + 1 - QUO_INT;

	aligned_t  dvs_shift;
	aligned_t  acc_try;
	logic      fit;
	quotient_t quo_nxt;

	// trial add of the weighted divisor
	always_comb begin
		dvs_shift = (in_dvs << SHL) >> SHR;
		acc_try   = in_acc + dvs_shift;
		fit       = (acc_try <= in_dvd);
		quo_nxt   = in_quo;
		quo_nxt[QBIT] = fit;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			out_vld  <= 1'b0;
			out_sign <= 1'b0;
			out_dvd  <= '0;
			out_dvs  <= '0;
			out_acc  <= '0;
			out_quo  <= '0;
		end else begin
			out_vld  <= in_vld;
			out_sign <= in_sign;
			out_dvd  <= in_dvd;
			out_dvs  <= in_dvs;
			// restore by keeping the old sum when it does not fit
			out_acc  <= fit ? acc_try : in_acc;
			out_quo  <= quo_nxt;
		end
	end

endmodule

// File: rtl/div_round_saturate.sv
`timescale 1ns/1ps

module div_round_saturate #(
	parameter int ROUND = 1
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   in_vld,
	input  logic                   in_sign,
	input  fxp_div_pkg::aligned_t  in_dvd,
	input  fxp_div_pkg::aligned_t  in_dvs,
	input  fxp_div_pkg::aligned_t  in_acc,
	input  fxp_div_pkg::quotient_t in_quo,
	output logic                   rdy,
	output fxp_div_pkg::quotient_t quot,
	output logic                   overflow
);

	import fxp_div_pkg::*;

	localparam quotient_t QUO_MAX = '1;
	localparam quotient_t POS_MAX = {1'b0, {(QUO_W-1){1'b1}}};
	localparam quotient_t NEG_MIN = {1'b1, {(QUO_W-1){1'b0}}};

	logic [ALN_W:0] rem2;
	aligned_t       lsb_dvs;
	logic           rnd_up;

	logic           rnd_vld;
	logic           rnd_sign;
	quotient_t      rnd_mag;

	quotient_t      sat_quo;
	logic           sat_ovf;

	// --------------------------------------------------
	// round half up on the magnitude
	// --------------------------------------------------

	// divisor weight of one quotient lsb, compared with twice the remainder
	always_comb begin
		rem2    = {in_dvd - in_acc, 1'b0};
		lsb_dvs = in_dvs >> QUO_FRAC;
		rnd_up  = (ROUND != 0) && (in_quo != QUO_MAX) && (rem2 >= {1'b0, lsb_dvs});
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rnd_vld  <= 1'b0;
			rnd_sign <= 1'b0;
			rnd_mag  <= '0;
		end else begin
			rnd_vld  <= in_vld;
			rnd_sign <= in_sign;
			rnd_mag  <= in_quo + quotient_t'(rnd_up);
		end
	end

	// --------------------------------------------------
	// sign restore and saturation
	// --------------------------------------------------

	// negative side reaches one step further than positive
	always_comb begin
		if (!rnd_sign) begin
			sat_ovf = rnd_mag[QUO_W-1];
			sat_quo = sat_ovf ? POS_MAX : rnd_mag;
		end else begin
			sat_ovf = (rnd_mag > NEG_MIN);
			sat_quo = rnd_mag[QUO_W-1] ? NEG_MIN : -rnd_mag;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rdy      <= 1'b0;
			quot     <= '0;
			overflow <= 1'b0;
		end else begin
			rdy      <= rnd_vld;
			quot     <= sat_quo;
			// bubbles carry stale data, keep the flag to real results
			overflow <= rnd_vld & sat_ovf;
		end
	end

endmodule

// File: rtl/fxp_div_top.sv
`timescale 1ns/1ps

module fxp_div_top #(
	parameter int ROUND = 1
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   vld,
	input  fxp_div_pkg::dividend_t dividend,
	input  fxp_div_pkg::divisor_t  divisor,
	output logic                   rdy,
	output fxp_div_pkg::quotient_t quot,
	output logic                   overflow
);

	import fxp_div_pkg::*;

	// index 0 is the operand stage, index k+1 the output of divider stage k
	logic      stg_vld  [QUO_W+1];
	logic      stg_sign [QUO_W+1];
	aligned_t  stg_dvd  [QUO_W+1];
	aligned_t  stg_dvs  [QUO_W+1];
	aligned_t  stg_acc  [QUO_W+1];
	quotient_t stg_quo  [QUO_W+1];

	// --------------------------------------------------
	// input side
	// --------------------------------------------------

	div_operand_stage div_operand_stage_inst (
		.clk      (clk),
		.rstn     (rstn),
		.vld      (vld),
		.dividend (dividend),
		.divisor  (divisor),
		.out_vld  (stg_vld[0]),
		.out_sign (stg_sign[0]),
		.out_dvd  (stg_dvd[0]),
		.out_dvs  (stg_dvs[0])
	);

	// divider chain starts from an empty sum and quotient
	assign stg_acc[0] = '0;
	assign stg_quo[0] = '0;

	// --------------------------------------------------
	// restoring divider chain
	// --------------------------------------------------

	for (genvar k = 0; k < QUO_W; k++) begin : g_stage
		div_restoring_stage #(
			.STAGE (k)
		) div_restoring_stage_inst (
			.clk      (clk),
			.rstn     (rstn),
			.in_vld   (stg_vld[k]),
			.in_sign  (stg_sign[k]),
			.in_dvd   (stg_dvd[k]),
			.in_dvs   (stg_dvs[k]),
			.in_acc   (stg_acc[k]),
			.in_quo   (stg_quo[k]),
			.out_vld  (stg_vld[k+1]),
			.out_sign (stg_sign[k+1]),
			.out_dvd  (stg_dvd[k+1]),
			.out_dvs  (stg_dvs[k+1]),
			.out_acc  (stg_acc[k+1]),
			.out_quo  (stg_quo[k+1])
		);
	end

	// output side
	div_round_saturate #(
		.ROUND (ROUND)
	) div_round_saturate_inst (
		.clk      (clk),
		.rstn     (rstn),
		.in_vld   (stg_vld[QUO_W]),
		.in_sign  (stg_sign[QUO_W]),
		.in_dvd   (stg_dvd[QUO_W]),
		.in_dvs   (stg_dvs[QUO_W]),
		.in_acc   (stg_acc[QUO_W]),
		.in_quo   (stg_quo[QUO_W]),
		.rdy      (rdy),
		.quot     (quot),
		.overflow (overflow)
	);

endmodule

// File: dv/fxp_div_properties.sv
`timescale 1ns/1ps

module fxp_div_properties (
	input logic                   clk,
	input logic                   rstn,
	input logic                   vld,
	input logic                   rdy,
	input fxp_div_pkg::quotient_t quot,
	input logic                   overflow
);

	import fxp_div_pkg::*;

	// --------------------------------------------------
	// pipeline timing
	// --------------------------------------------------

	// fixed latency, no stalls anywhere in the chain
	a_latency: assert property (@(posedge clk) disable iff (!rstn)
		rdy == $past(vld, DIV_LATENCY))
		else $error("rdy does not follow vld after the pipeline latency");

	// --------------------------------------------------
	// output consistency
	// --------------------------------------------------

	a_ovf_with_rdy: assert property (@(posedge clk) disable iff (!rstn)
		overflow |-> rdy)
		else $error("overflow high without rdy");

	// overflow always comes with a saturated quotient
	a_ovf_saturated: assert property (@(posedge clk) disable iff (!rstn)
		overflow |-> (quot == 16'h7fff || quot == 16'h8000))
		else $error("overflow high with a quotient that is not saturated");

endmodule

bind fxp_div_top fxp_div_properties fxp_div_properties_inst (
	.clk      (clk),
	.rstn     (rstn),
	.vld      (vld),
	.rdy      (rdy),
	.quot     (quot),
	.overflow (overflow)
);

// File: dv/fxp_div_tb.sv
`timescale 1ns/1ps

module fxp_div_tb;

	import fxp_div_pkg::*;

	// pair counts per test, gaps in the burst are at most one per pair
	localparam int N_STREAM = 200;
	localparam int N_BURST  = 30;
	localparam int N_PAIRS  = 4 + 4 + 4 + N_STREAM + N_BURST;
	localparam int WATCHDOG_CYCLES = N_PAIRS + N_BURST + 5 * DIV_LATENCY + 50;

	// dividend frac 8, divisor frac 4, quotient frac 8
	localparam int SCALE   = 16;
	localparam int MAG_MAX = 65535;

	logic      clk;
	logic      rstn;
	logic      vld;
	dividend_t dividend;
	divisor_t  divisor;
	logic      rdy;
	quotient_t quot;
	logic      overflow;

	logic [31:0] lfsr = 32'hab58;
	quotient_t   exp_quot[$];
	logic        exp_ovf[$];
	string       exp_name[$];
	int          errors   = 0;
	int          n_checks = 0;
	int          n_vld    = 0;
	int          n_rdy    = 0;

	fxp_div_top #(
		.ROUND (1)
	) fxp_div_top_inst (
		.clk      (clk),
		.rstn     (rstn),
		.vld      (vld),
		.dividend (dividend),
		.divisor  (divisor),
		.rdy      (rdy),
		.quot     (quot),
		.overflow (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// --------------------------------------------------
	// random bits and reference model
	// --------------------------------------------------

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// returns {overflow, quot}
	function automatic logic [16:0] ref_div(input dividend_t a, input divisor_t b);
		int        mag_a;
		int        mag_b;
		int        num;
		int        q;
		logic      neg;
		quotient_t res;
		logic      ovf;
		mag_a = (a < 0) ? -int'(a) : int'(a);
		mag_b = (b < 0) ? -int'(b) : int'(b);
		neg   = a[15] ^ b[7];
		num   = mag_a * SCALE;
		q     = (mag_b == 0) ? MAG_MAX : num / mag_b;
		if (q > MAG_MAX)
			q = MAG_MAX;
		// round half up, never past all ones
		if (q != MAG_MAX && mag_b != 0 && 2 * (num - q * mag_b) >= mag_b)
			q = q + 1;
		if (!neg) begin
			ovf = (q >= 32768);
			res = ovf ? 16'h7fff : quotient_t'(q);
		end else begin
			ovf = (q > 32768);
			res = (q >= 32768) ? 16'h8000 : quotient_t'(-q);
		end
		return {ovf, res};
	endfunction

	// --------------------------------------------------
	// drive helpers
	// --------------------------------------------------

	task automatic drive_pair(input dividend_t a, input divisor_t b,
			input quotient_t e_q, input logic e_o, input string name);
		@(posedge clk);
		#1;
		vld      = 1'b1;
		dividend = a;
		divisor  = b;
		exp_quot.push_back(e_q);
		exp_ovf.push_back(e_o);
		exp_name.push_back(name);
		n_vld++;
	endtask

	task automatic drive_model(input dividend_t a, input divisor_t b, input string name);
		logic [16:0] r;
		r = ref_div(a, b);
		drive_pair(a, b, r[15:0], r[16], name);
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		vld = 1'b0;
	endtask

	task automatic wait_drain();
		drive_idle();
		while (exp_quot.size() != 0)
			@(posedge clk);
	endtask

	task automatic check_idle(input string name);
		assert (rdy == 1'b0 && overflow == 1'b0 && quot == '0) else begin
			$display("ERROR %s: expected rdy 0 ovf 0 quot 0000, actual rdy %b ovf %b quot %h",
				name, rdy, overflow, quot);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// scoreboard
	// --------------------------------------------------

	always @(negedge clk) begin : scoreboard
		quotient_t e_q;
		logic      e_o;
		string     name;
		if (rstn && rdy) begin
			n_rdy++;
			assert (exp_quot.size() != 0) else begin
				$display("rdy was high at %0t with no result outstanding", $time);
				errors++;
			end
			if (exp_quot.size() != 0) begin
				e_q  = exp_quot.pop_front();
				e_o  = exp_ovf.pop_front();
				name = exp_name.pop_front();
				n_checks++;
				assert (quot == e_q && overflow == e_o) else begin
					$display("ERROR %s: expected quot %h ovf %b, actual quot %h ovf %b",
						name, e_q, e_o, quot, overflow);
					errors++;
				end
			end
		end
	end

	// --------------------------------------------------
	// tests
	// --------------------------------------------------

	task automatic test_reset();
		rstn = 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_idle("reset");
			@(posedge clk);
		end
		#1 rstn = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_idle("after_reset");
		end
	endtask

	task automatic test_exact();
		drive_pair(16'h0600, 8'h20, 16'h0300, 1'b0, "exact");
		drive_pair(16'hfa00, 8'h20, 16'hfd00, 1'b0, "exact");
		drive_pair(16'h0600, 8'he8, 16'hfc00, 1'b0, "exact");
		drive_pair(16'hff00, 8'hfc, 16'h0400, 1'b0, "exact");
		wait_drain();
	endtask

	// 2.0/3.0 rounds up, truncation would give 00aa
	task automatic test_rounding();
		drive_pair(16'h0100, 8'h30, 16'h0055, 1'b0, "rounding");
		drive_pair(16'hfe00, 8'h30, 16'hff55, 1'b0, "rounding");
		drive_pair(16'h0001, 8'h7f, 16'h0000, 1'b0, "rounding");
		drive_pair(16'h0200, 8'h30, 16'h00ab, 1'b0, "rounding");
		wait_drain();
	endtask

	task automatic test_saturation();
		drive_pair(16'h7f00, 8'h01, 16'h7fff, 1'b1, "saturation");
		drive_pair(16'h0100, 8'h00, 16'h7fff, 1'b1, "saturation");
		drive_pair(16'h8000, 8'h10, 16'h8000, 1'b0, "saturation");
		drive_pair(16'h8100, 8'h01, 16'h8000, 1'b1, "saturation");
		wait_drain();
	endtask

	task automatic test_streaming();
		dividend_t a;
		divisor_t  b;
		repeat (N_STREAM) begin
			a = dividend_t'(take_bits(16));
			b = divisor_t'(take_bits(8));
			drive_model(a, b, "stream");
		end
		wait_drain();
		// same traffic with random holes in vld
		repeat (N_BURST) begin
			a = dividend_t'(take_bits(16));
			b = divisor_t'(take_bits(8));
			drive_model(a, b, "burst");
			if (take_bits(1) != 0)
				drive_idle();
		end
		wait_drain();
	endtask

	// --------------------------------------------------
	// main sequence and watchdog
	// --------------------------------------------------

	initial begin
		rstn     = 1'b0;
		vld      = 1'b0;
		dividend = '0;
		divisor  = '0;
		test_reset();
		test_exact();
		test_rounding();
		test_saturation();
		test_streaming();
		assert (n_rdy == n_vld) else begin
			$display("rdy count %0d does not match vld count %0d", n_rdy, n_vld);
			errors++;
		end
		$display("checks %0d, vld %0d, rdy %0d, errors %0d", n_checks, n_vld, n_rdy, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, %0d results still outstanding",
			WATCHDOG_CYCLES, exp_quot.size());
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: list.f
rtl/fxp_div_pkg.sv
rtl/div_operand_stage.sv
rtl/div_restoring_stage.sv
rtl/div_round_saturate.sv
rtl/fxp_div_top.sv
dv/fxp_div_properties.sv
dv/fxp_div_tb.sv

// File: run.sh
#!/bin/bash
# compile and run the divider testbench with verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module fxp_div_tb \
	&& ./obj_dir/Vfxp_div_tb 2>&1 | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
	&& { echo "test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
	|| { echo "no result found in sim.log"; exit 1; }

echo "test passed"
exit 0
